//--- rvCore.f
+incdir+src
src/rvPkg.sv
src/controlDecoder.sv
src/immGen.sv
src/alu.sv
src/regFile.sv
src/dataMem.sv
src/pcUnit.sv
src/rvCore.sv
tb/clockGen.sv
tb/rvCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the rvCore testbench with Verilator.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f rvCore.f --top-module rvCoreTb -o rvCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/rvCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

//--- tb/rvCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_defines.svh"

module rvCoreTb import rvPkg::*; ();

    localparam logic [31:0] NOP = 32'h00000013;  // addi x0, x0, 0
    localparam int MAX_STEPS = 200;              // per program
    localparam int TIMEOUT_NS = (5 * (MAX_STEPS + 8)) * 4 + 400;

    logic        clk;
    logic        genReset;
    logic        tbReset;
    logic        dutReset;
    logic [31:0] instr;
    logic [31:0] pc;
    traceInfo    trace;
    logic [31:0] prog [64];   // instruction memory model
    int          progLen;
    logic [31:0] lfsrState;
    logic [31:0] mRegs [32];  // reference model state
    logic [7:0]  mMem [`DMEM_BYTES];
    logic [31:0] mPc;

    assign dutReset = genReset || tbReset;

    clockGen u_clockGen (.clk(clk), .reset(genReset));

    rvCore i_dut (.clk(clk), .reset(dutReset), .instr(instr), .pc(pc), .trace(trace));

    always @(posedge clk) begin
        #1 instr = prog[pc[7:2]];  // fetch for the new pc
    end

    initial begin
        #(TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog: simulation still running after %0d ns", TIMEOUT_NS);
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h80200003 : lfsrState >> 1;
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic clearProgram();
        for (int i = 0; i < 64; i++) begin
            prog[i] = NOP;
        end
        progLen = 0;
    endtask

    task automatic loadRand(input logic [4:0] rd);  // lui + addi
        logic [31:0] v;
        v = randBits(32);
        emit({v[31:12], rd, 7'h37});
        emit(encI(v[11:0], rd, 3'd0, rd, 7'h13));
    endtask

    task automatic checkEq(input string test, input string what, input logic [31:0] exp,
                           input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", test, what, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch in %s", test);
        end
    endtask

    // rv32i reference model for one instruction
    task automatic modelStep(input logic [31:0] ins, output logic en, output logic [31:0] data);
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] iImm;
        logic [31:0] sImm;
        logic [31:0] bImm;
        logic [31:0] jImm;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] nextPc;
        logic        taken;
        op     = ins[6:0];
        f3     = ins[14:12];
        a      = mRegs[ins[19:15]];
        iImm   = {{20{ins[31]}}, ins[31:20]};
        sImm   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        bImm   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        jImm   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        b      = (op == 7'h33 || op == 7'h63 || op == 7'h23) ? mRegs[ins[24:20]] : iImm;
        en     = 1'b0;
        data   = '0;
        taken  = 1'b0;
        nextPc = mPc + 4;
        case (op)
            7'h13, 7'h33: begin
                en = 1'b1;
                case (f3)
                    3'd0: data = (op == 7'h33 && ins[30]) ? a - b : a + b;
                    3'd1: data = a << b[4:0];
                    3'd2: data = 32'($signed(a) < $signed(b));
                    3'd3: data = 32'(a < b);
                    3'd4: data = a ^ b;
                    3'd5: data = (op == 7'h33 && ins[30]) ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'd6: data = a | b;
                    default: data = a & b;
                endcase
            end
            7'h37: begin
                en = 1'b1;
                data = {ins[31:12], 12'b0};
            end
            7'h03: begin
                en = 1'b1;
                addr = (a + iImm) % `DMEM_BYTES;
                word = {mMem[addr + 3], mMem[addr + 2], mMem[addr + 1], mMem[addr]};
                case (f3)
                    3'd0: data = {{24{word[7]}}, word[7:0]};
                    3'd1: data = {{16{word[15]}}, word[15:0]};
                    3'd4: data = {24'b0, word[7:0]};
                    3'd5: data = {16'b0, word[15:0]};
                    default: data = word;
                endcase
            end
            7'h23: begin
                addr = (a + sImm) % `DMEM_BYTES;
                mMem[addr] = b[7:0];
                if (f3 != 3'd0) mMem[addr + 1] = b[15:8];
                if (f3 == 3'd2) begin
                    mMem[addr + 2] = b[23:16];
                    mMem[addr + 3] = b[31:24];
                end
            end
            7'h63: begin
                case (f3)
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) nextPc = mPc + bImm;
            end
            7'h6f: begin
                en = 1'b1;
                data = mPc + 4;
                nextPc = mPc + jImm;
            end
            7'h67: begin
                en = 1'b1;
                data = mPc + 4;
                nextPc = (a + iImm) & ~32'd1;
            end
            default: ;  // unknown op only moves the pc
        endcase
        if (en && ins[11:7] != 5'd0) mRegs[ins[11:7]] = data;
        mPc = nextPc;
    endtask

    task automatic pulseReset(input string name);
        @(posedge clk);
        #1 tbReset = 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkEq(name, "wbEn in reset", 32'd0, 32'(trace.wbEn));
            @(posedge clk);
        end
        #1 tbReset = 1'b0;
    endtask

    task automatic stepOne(input string name);
        logic [31:0] ins;
        logic [31:0] pcNow;
        logic [31:0] data;
        logic        en;
        @(negedge clk);  // trace settled for this instruction
        ins   = prog[mPc[7:2]];
        pcNow = mPc;
        modelStep(ins, en, data);
        checkEq(name, "fetch pc", pcNow, pc);
        checkEq(name, "pc", pcNow, trace.pc);
        checkEq(name, "wbEn", 32'(en), 32'(trace.wbEn));
        if (en) begin
            checkEq(name, "wbAddr", 32'(ins[11:7]), 32'(trace.wbAddr));
            checkEq(name, "wbData", data, trace.wbData);
        end
        @(posedge clk);
    endtask

    task automatic runProgram(input string name);
        int steps;
        pulseReset(name);
        for (int i = 0; i < 32; i++) mRegs[i] = '0;
        mPc = '0;
        steps = 0;
        while (mPc != 32'(progLen * 4)) begin
            if (steps == MAX_STEPS) begin
                $display("TEST RESULT: FAIL");
                $fatal(1, "%s: program never reached its last instruction", name);
            end
            stepOne(name);
            steps++;
        end
    endtask

    task automatic aluTest();
        logic [6:0] f7s [10] = '{0, 7'h20, 0, 0, 0, 0, 0, 7'h20, 0, 0};
        logic [2:0] f3s [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        clearProgram();
        loadRand(5'd1);
        loadRand(5'd2);
        foreach (f3s[i]) begin
            if (f3s[i] != 3'd3 && f3s[i] != 3'd1 && f3s[i] != 3'd5 && f7s[i] == 0) begin
                emit(encI(12'(randBits(12)), 5'd1, f3s[i], 5'd3, 7'h13));
            end
        end
        emit(encI({7'b0, 5'(randBits(5))}, 5'd1, 3'd1, 5'd4, 7'h13));  // slli
        emit(encI({7'b0, 5'(randBits(5))}, 5'd1, 3'd5, 5'd4, 7'h13));  // srli
        foreach (f3s[i]) begin
            emit(encR(f7s[i], 5'd2, 5'd1, f3s[i], 5'd6));
            emit(encR(f7s[i], 5'd1, 5'd2, f3s[i], 5'd7));
        end
        runProgram("aluTest");
    endtask

    task automatic luiX0Test();
        clearProgram();
        emit({20'(randBits(20)), 5'd0, 7'h37});   // lui x0
        emit({20'(randBits(20)), 5'd9, 7'h37});
        emit(encR(7'd0, 5'd0, 5'd0, 3'd0, 5'd3));  // add x3, x0, x0
        runProgram("luiX0Test");
    endtask

    task automatic memTest();
        clearProgram();
        loadRand(5'd1);
        loadRand(5'd2);
        emit(encI({3'b0, 7'(randBits(7)), 2'b00}, 5'd0, 3'd0, 5'd5, 7'h13));
        emit(encS(12'd0, 5'd1, 5'd5, 3'd2));  // sw
        emit(encS(12'd4, 5'd2, 5'd5, 3'd1));  // sh
        emit(encS(12'd6, 5'd2, 5'd5, 3'd0));  // sb
        emit(encS(12'd7, 5'd1, 5'd5, 3'd0));
        for (int off = 0; off < 8; off++) begin
            emit(encI(12'(off), 5'd5, 3'd0, 5'd6, 7'h03));   // lb
            emit(encI(12'(off), 5'd5, 3'd4, 5'd6, 7'h03));   // lbu
            if (off % 2 == 0) begin
                emit(encI(12'(off), 5'd5, 3'd1, 5'd7, 7'h03));  // lh
                emit(encI(12'(off), 5'd5, 3'd5, 5'd7, 7'h03));  // lhu
            end
        end
        emit(encI(12'd4, 5'd5, 3'd2, 5'd8, 7'h03));  // lw
        runProgram("memTest");
    endtask

    task automatic branchTest();
        logic [2:0] kinds [6] = '{0, 1, 4, 5, 6, 7};
        clearProgram();
        loadRand(5'd1);
        loadRand(5'd2);
        foreach (kinds[k]) begin
            emit(encB(13'd8, 5'd2, 5'd1, kinds[k]));
            emit(encI(12'd1, 5'd7, 3'd0, 5'd7, 7'h13));  // skipped when taken
            emit(encB(13'd8, 5'd1, 5'd2, kinds[k]));
            emit(encI(12'd1, 5'd7, 3'd0, 5'd7, 7'h13));
            emit(encB(13'd8, 5'd1, 5'd1, kinds[k]));
            emit(encI(12'd1, 5'd7, 3'd0, 5'd7, 7'h13));
        end
        runProgram("branchTest");
    endtask

    task automatic jumpTest();
        clearProgram();
        emit(encJ(21'd12, 5'd1));                       // to index 3
        emit(encI(12'd1, 5'd7, 3'd0, 5'd7, 7'h13));
        emit(encI(12'd1, 5'd7, 3'd0, 5'd7, 7'h13));
        emit(encI(12'd24, 5'd0, 3'd0, 5'd4, 7'h13));
        emit(encI(12'd1, 5'd4, 3'd0, 5'd5, 7'h67));    // 25 rounds down to 24
        emit(encI(12'd1, 5'd7, 3'd0, 5'd7, 7'h13));
        emit(encR(7'd0, 5'd5, 5'd1, 3'd0, 5'd6));
        runProgram("jumpTest");
    endtask

    initial begin
        instr     = NOP;
        tbReset   = 1'b0;
        lfsrState = 32'h91f2d7ea;
        clearProgram();
        @(negedge genReset);
        aluTest();
        luiX0Test();
        memTest();
        branchTest();
        jumpTest();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #2 clk = !clk;  // 4 ns period
    end

    initial begin
        repeat (3) @(posedge clk);  // power-on reset, 3 cycles
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- src/rvCore.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_defines.svh"

module rvCore import rvPkg::*; (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic [`XLEN-1:0] instr,  // fetched from pc this cycle
    output logic [`XLEN-1:0]      pc,
    output traceInfo              trace
);

    ctrlSignals       ctrl;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] loadData;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] wbData;
    logic             flag;
    logic             wbEn;
    logic             ramWrite;

    assign wbEn     = ctrl.regWrite && !reset;  // no commits while in reset
    assign ramWrite = ctrl.ramWrite && !reset;
    assign srcB     = ctrl.aluSrc ? imm : rs2Data;

    controlDecoder u_decoder (.instr(instr), .flag(flag), .ctrl(ctrl));

    immGen u_immGen (.instr(instr), .immSrc(ctrl.immSrc), .imm(imm));

    regFile u_regFile (
        .clk(clk), .reset(reset),
        .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .wbEn(wbEn), .wbAddr(instr[11:7]), .wbData(wbData)
    );

    alu u_alu (
        .srcA(rs1Data), .srcB(srcB), .aluOp(ctrl.aluOp),
        .funct3(instr[14:12]), .funct7b5(instr[30]), .regOp(instr[5]),
        .result(aluResult), .flag(flag)
    );

    dataMem u_dataMem (
        .clk(clk), .addr(aluResult), .storeData(rs2Data),
        .ramWrite(ramWrite), .funct3(instr[14:12]), .loadData(loadData)
    );

    pcUnit u_pcUnit (
        .clk(clk), .reset(reset), .pcSrc(ctrl.pcSrc), .imm(imm),
        .aluResult(aluResult), .pc(pc), .pcPlus4(pcPlus4)
    );

    always_comb begin
        case (ctrl.resultSrc)
            resMem:     wbData = loadData;
            resPcPlus4: wbData = pcPlus4;  // jal / jalr link
            resImm:     wbData = imm;      // lui
            default:    wbData = aluResult;
        endcase
    end

    always_comb begin
        trace.wbEn   = wbEn;
        trace.wbAddr = instr[11:7];
        trace.wbData = wbData;
        trace.pc     = pc;
    end

endmodule

`default_nettype wire

//--- src/pcUnit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_defines.svh"

module pcUnit import rvPkg::*; (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire pcSrcKind         pcSrc,
    input  wire logic [`XLEN-1:0] imm,
    input  wire logic [`XLEN-1:0] aluResult,  // jalr target
    output logic [`XLEN-1:0]      pc,
    output logic [`XLEN-1:0]      pcPlus4
);

    logic [`XLEN-1:0] pcImm;
    logic [`XLEN-1:0] nextPc;

    assign pcPlus4 = pc + `XLEN'(4);
    assign pcImm   = pc + imm;  // branch and jal

    always_comb begin
        case (pcSrc)
            pcTarget:    nextPc = pcImm;
            pcAluTarget: nextPc = {aluResult[`XLEN-1:1], 1'b0};  // bit 0 cleared
            default:     nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- src/dataMem.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_defines.svh"

module dataMem (
    input  wire logic             clk,
    input  wire logic [`XLEN-1:0] addr,
    input  wire logic [`XLEN-1:0] storeData,
    input  wire logic             ramWrite,
    input  wire logic [2:0]       funct3,     // access size and sign
    output logic [`XLEN-1:0]      loadData
);

    localparam int ADDR_BITS = $clog2(`DMEM_BYTES);

    logic [7:0]           mem [`DMEM_BYTES];
    logic [ADDR_BITS-1:0] a0;
    logic [ADDR_BITS-1:0] a1;
    logic [ADDR_BITS-1:0] a2;
    logic [ADDR_BITS-1:0] a3;
    logic [`XLEN-1:0]     word;
    logic [2:0]           accessBytes;

    assign a0 = addr[ADDR_BITS-1:0];
    assign a1 = a0 + ADDR_BITS'(1);
    assign a2 = a0 + ADDR_BITS'(2);
    assign a3 = a0 + ADDR_BITS'(3);
    assign word = {mem[a3], mem[a2], mem[a1], mem[a0]};  // little-endian

    always_comb begin
        case (funct3)
            3'b000:  loadData = {{(`XLEN-8){word[7]}}, word[7:0]};     // lb
            3'b001:  loadData = {{(`XLEN-16){word[15]}}, word[15:0]};  // lh
            3'b100:  loadData = {{(`XLEN-8){1'b0}}, word[7:0]};        // lbu
            3'b101:  loadData = {{(`XLEN-16){1'b0}}, word[15:0]};      // lhu
            default: loadData = word;                                  // lw
        endcase
    end

    always_comb begin
        case (funct3[1:0])
            2'b00:   accessBytes = 3'd1;
            2'b01:   accessBytes = 3'd2;
            default: accessBytes = 3'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ramWrite) begin
            mem[a0] <= storeData[7:0];  // every store size
            if (funct3[1:0] != 2'b00) begin
                mem[a1] <= storeData[15:8];
            end
            if (funct3[1]) begin  // sw only
                mem[a2] <= storeData[23:16];
                mem[a3] <= storeData[31:24];
            end
        end
    end

    // the whole store lands inside the array
    assert property (@(posedge clk)
        ramWrite |-> ({1'b0, addr} + accessBytes <= `DMEM_BYTES))
        else $error("dataMem: store at 0x%h runs past the RAM", addr);

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_defines.svh"

module regFile (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic [4:0]       rs1Addr,
    input  wire logic [4:0]       rs2Addr,
    output logic [`XLEN-1:0]      rs1Data,
    output logic [`XLEN-1:0]      rs2Data,
    input  wire logic             wbEn,
    input  wire logic [4:0]       wbAddr,
    input  wire logic [`XLEN-1:0] wbData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    assign rs1Data = regs[rs1Addr];  // async read
    assign rs2Data = regs[rs2Addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbAddr != '0) begin  // x0 writes dropped
            regs[wbAddr] <= wbData;
        end
    end

    // x0 stays zero across any sequence of writes
    assert property (@(posedge clk) disable iff (reset)
        (rs1Addr != '0 || rs1Data == '0) && (rs2Addr != '0 || rs2Data == '0))
        else $error("regFile: x0 read back nonzero");

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_defines.svh"

module alu import rvPkg::*; (
    input  wire logic [`XLEN-1:0] srcA,
    input  wire logic [`XLEN-1:0] srcB,
    input  wire aluOpKind         aluOp,
    input  wire logic [2:0]       funct3,
    input  wire logic             funct7b5,  // sub / sra select
    input  wire logic             regOp,     // opcode bit 5, r-type only
    output logic [`XLEN-1:0]      result,
    output logic                  flag
);

    localparam int SHAMT_BITS = $clog2(`XLEN);

    logic [`XLEN-1:0]      sum;
    logic [`XLEN-1:0]      diff;
    logic [SHAMT_BITS-1:0] shamt;
    logic                  lessSigned;
    logic                  lessUnsigned;
    logic                  equal;
    logic                  altOp;

    assign sum          = srcA + srcB;
    assign diff         = srcA - srcB;
    assign shamt        = srcB[SHAMT_BITS-1:0];  // low bits only
    assign lessSigned   = $signed(srcA) < $signed(srcB);
    assign lessUnsigned = srcA < srcB;
    assign equal        = srcA == srcB;
    assign altOp        = regOp && funct7b5;  // i-type ignores funct7

    always_comb begin
        result = sum;
        flag   = 1'b0;
        case (aluOp)
            aluAdd: result = sum;  // load/store address
            aluJump: begin
                result = sum;  // jalr target
                flag   = 1'b1;
            end
            aluBranch: begin
                result = diff;
                case (funct3)
                    3'b000:  flag = equal;          // beq
                    3'b001:  flag = !equal;         // bne
                    3'b100:  flag = lessSigned;     // blt
                    3'b101:  flag = !lessSigned;    // bge
                    3'b110:  flag = lessUnsigned;   // bltu
                    3'b111:  flag = !lessUnsigned;  // bgeu
                    default: flag = 1'b0;
                endcase
            end
            aluFunct: begin
                case (funct3)
                    3'b000:  result = altOp ? diff : sum;
                    3'b001:  result = srcA << shamt;
                    3'b010:  result = {{(`XLEN-1){1'b0}}, lessSigned};
                    3'b011:  result = {{(`XLEN-1){1'b0}}, lessUnsigned};
                    3'b100:  result = srcA ^ srcB;
                    3'b101:  result = altOp ? `XLEN'($signed(srcA) >>> shamt) : srcA >> shamt;
                    3'b110:  result = srcA | srcB;
                    default: result = srcA & srcB;
                endcase
            end
            default: result = sum;
        endcase
    end

endmodule

`default_nettype wire

//--- src/immGen.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_defines.svh"

module immGen import rvPkg::*; (
    input  wire logic [`XLEN-1:0] instr,
    input  wire immKind           immSrc,
    output logic [`XLEN-1:0]      imm
);

    logic sign;

    assign sign = instr[31];  // every format keeps its sign here

    always_comb begin
        case (immSrc)
            immI: imm = {{(`XLEN-12){sign}}, instr[31:20]};
            immS: imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};  // split field
            immB: imm = {{(`XLEN-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immU: imm = {instr[31:12], 12'b0};  // upper 20 bits
            immJ: imm = {{(`XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/controlDecoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_defines.svh"

module controlDecoder import rvPkg::*; (
    input  wire logic [`XLEN-1:0] instr,
    input  wire logic             flag,   // branch condition from alu
    output ctrlSignals            ctrl
);

    opcodeKind    op;
    immKind       immSrc;
    logic         aluSrc;
    aluOpKind     aluOp;
    logic         regWrite;
    logic         ramWrite;
    pcSrcKind     pcReq;       // request before the flag is applied
    pcSrcKind     pcSrc;
    resultSrcKind resultSrc;

    assign op = opcodeKind'(instr[6:0]);  // major opcode sits in the low bits

    always_comb begin
        case (op)
            opImm, opLoad, opJalr: immSrc = immI;
            opStore:               immSrc = immS;
            opBranch:              immSrc = immB;
            opLui:                 immSrc = immU;
            opJal:                 immSrc = immJ;
            default:               immSrc = immI;
        endcase
    end

    always_comb begin
        case (op)
            opImm, opLoad, opStore, opJalr, opLui, opJal: aluSrc = 1'b1;
            default:                                      aluSrc = 1'b0;  // r-type, branch
        endcase
    end

    always_comb begin
        case (op)
            opBranch:     aluOp = aluBranch;
            opImm, opReg: aluOp = aluFunct;
            opJal, opJalr: aluOp = aluJump;  // unconditional via flag
            default:      aluOp = aluAdd;    // load/store address too
        endcase
    end

    always_comb begin
        case (op)
            opImm, opReg, opLoad, opLui, opJal, opJalr: regWrite = 1'b1;
            default:                                    regWrite = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            opStore: ramWrite = 1'b1;
            default: ramWrite = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            opBranch, opJal: pcReq = pcTarget;
            opJalr:          pcReq = pcAluTarget;
            default:         pcReq = pcPlus4;  // unknown ops fall through
        endcase
    end

    always_comb begin
        case (op)
            opLoad:        resultSrc = resMem;
            opJal, opJalr: resultSrc = resPcPlus4;
            opLui:         resultSrc = resImm;
            default:       resultSrc = resAlu;
        endcase
    end

    // not-taken branch drops back to pc+4
    assign pcSrc = (pcReq == pcTarget && !flag) ? pcPlus4 : pcReq;

    always_comb begin
        ctrl.regWrite  = regWrite;
        ctrl.ramWrite  = ramWrite;
        ctrl.aluOp     = aluOp;
        ctrl.aluSrc    = aluSrc;
        ctrl.immSrc    = immSrc;
        ctrl.pcSrc     = pcSrc;
        ctrl.resultSrc = resultSrc;
    end

endmodule

`default_nettype wire

//--- src/rvPkg.sv
`default_nettype none

`include "rvCore_defines.svh"

package rvPkg;

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,  // i-type layout
        opJal    = 7'b1101111
    } opcodeKind;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immU = 3'b011,
        immJ = 3'b100
    } immKind;

    typedef enum logic [1:0] {
        aluAdd    = 2'b00,  // load/store address
        aluBranch = 2'b01,  // compare picked by funct3
        aluFunct  = 2'b10,  // i-type and r-type ops
        aluJump   = 2'b11   // jalr target, flag forced high
    } aluOpKind;

    // bit 1 marks the alu target, bit 0 gets anded with the flag
    typedef enum logic [1:0] {
        pcPlus4     = 2'b00,
        pcTarget    = 2'b01,  // pc + imm
        pcAluTarget = 2'b11   // rs1 + imm
    } pcSrcKind;

    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10,  // link address
        resImm     = 2'b11   // lui
    } resultSrcKind;

    typedef struct packed {
        logic         regWrite;
        logic         ramWrite;
        aluOpKind     aluOp;
        logic         aluSrc;     // imm as operand b
        immKind       immSrc;
        pcSrcKind     pcSrc;
        resultSrcKind resultSrc;
    } ctrlSignals;

    typedef struct packed {
        logic             wbEn;
        logic [4:0]       wbAddr;
        logic [`XLEN-1:0] wbData;
        logic [`XLEN-1:0] pc;       // pc of the retiring instruction
    } traceInfo;

endpackage

`default_nettype wire

//--- src/rvCore_defines.svh
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// data and address width
`define XLEN 32

`define REG_COUNT 32      // architectural registers, x0 included

`define DMEM_BYTES 1024   // data RAM size in bytes

`endif
